// File: rtl/dma_pkg.sv
package dma_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and ring geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int BUS_W      = 64;
  localparam int BURST_W    = 8;
  localparam int RING_IDX_W = 3; // eight descriptors in the ring

  localparam int MIN_FRAME_B = 60;
  localparam int MAX_FRAME_B = 1518;

  typedef logic [31:0]         addr_t;      // ddr word address
  typedef logic [BUS_W-1:0]    bus_word_t;
  typedef logic [BURST_W-1:0]  burst_t;
  typedef logic [10:0]         pack_len_t;  // frame length in bytes
  typedef logic [RING_IDX_W-1:0] ring_idx_t;
  typedef logic [15:0]         err_cnt_t;
  typedef logic [8:0]          credit_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // aux word layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int AUX_LEN_LSB   = 0;
  localparam int AUX_OWNER_BIT = 13; // 1 while the engine owns the descriptor
  localparam int AUX_ERR_LSB   = 14;
  localparam int AUX_BURST_LSB = 18;
  localparam int AUX_ADDR_LSB  = 32; // buffer word address in the upper half

  typedef enum logic [3:0] {
    TX_OK         = 4'd0,
    TX_SIZE_ERR   = 4'd3,
    TX_RD_TIMEOUT = 4'd4
  } err_code_t;

  // select codes for the indirect counter readout
  typedef enum logic [3:0] {
    SEL_RD_AUX_TIMEOUT  = 4'd1,
    SEL_OWNER_ERR       = 4'd2,
    SEL_SIZE_ERR        = 4'd3,
    SEL_RD_DATA_TIMEOUT = 4'd4,
    SEL_WR_AUX_TIMEOUT  = 4'd5,
    SEL_POSTPONED       = 4'd6,
    SEL_SENT            = 4'd12
  } cnt_sel_t;

endpackage

// File: rtl/tx_desc_ring.sv
`timescale 1ns/1ps

module tx_desc_ring import dma_pkg::*; #(
  parameter int DESC_STRIDE = 4
) (
  input  logic      ethSw,
  input  logic      rst,
  input  logic      work_ena,
  input  addr_t     ring_base,
  input  ring_idx_t host_prod_idx,
  input  logic      advance,
  output addr_t     cur_addr,
  output ring_idx_t cons_idx,
  output logic      pending
);

  // the host has posted work while its producer index is ahead of ours
  assign pending = (cons_idx != host_prod_idx);

  always_ff @(posedge ethSw) begin
    if (rst || !work_ena) begin
      cons_idx <= '0;
      cur_addr <= ring_base; // a stopped engine restarts at the head of the ring
    end
    else if (advance) begin
      cons_idx <= cons_idx + 1'b1;
      // last entry consumed, so the next descriptor sits at the base again
      if (&cons_idx)
        cur_addr <= ring_base;
      else
        cur_addr <= cur_addr + addr_t'(DESC_STRIDE);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the controller may only consume a descriptor the host has handed over
  a_advance_pending : assert property (
    @(posedge ethSw) disable iff (rst || !work_ena)
    advance |-> pending
  ) else $error("descriptor consumed while the ring was empty");

endmodule

// File: rtl/tx_dma_ctrl.sv
`timescale 1ns/1ps

module tx_dma_ctrl import dma_pkg::*; #(
  parameter int BUS_TIMEOUT = 1023
) (
  input  logic      ethSw,
  input  logic      rst,
  input  logic      work_ena,
  input  logic      pending,
  input  addr_t     cur_addr,
  input  logic      has_room,
  // ddr master bus
  output addr_t     ddr_address,
  output logic      ddr_read,
  output logic      ddr_write,
  output bus_word_t ddr_writedata,
  output burst_t    ddr_burstcount,
  input  bus_word_t ddr_readdata,
  input  logic      ddr_waitrequest,
  input  logic      ddr_readdatavalid,
  // transmit queue stream
  output bus_word_t tx_data,
  output logic      tx_valid,
  output logic      tx_sop,
  output logic      tx_eop,
  output logic      tx_err,
  // ring and credit handshake
  output logic      advance,
  output burst_t    need_words,
  // event pulses
  output logic      ev_rd_aux_timeout,
  output logic      ev_owner_err,
  output logic      ev_size_err,
  output logic      ev_rd_data_timeout,
  output logic      ev_wr_aux_timeout,
  output logic      ev_postponed,
  output logic      ev_sent,
  output logic      tx_irq
);

  localparam int BRAKE_W = $clog2(BUS_TIMEOUT + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_AUX,
    ST_AUX_CHECK,
    ST_CREDIT_CHECK,
    ST_PACK_RD,
    ST_END,
    ST_WR_AUX
  } dma_state_t;

  dma_state_t         state;
  bus_word_t          aux_word;   // working copy, written back at the end
  logic [BRAKE_W-1:0] brake_cnt;  // shared timer for every bus phase
  burst_t             beats_left;
  logic               first_word;

  pack_len_t aux_len;
  logic      aux_owner;
  addr_t     aux_buf_addr;
  logic      brake_timeout;
  logic      wr_done;

  assign aux_len       = aux_word[AUX_LEN_LSB +: $bits(pack_len_t)];
  assign aux_owner     = aux_word[AUX_OWNER_BIT];
  assign aux_buf_addr  = aux_word[AUX_ADDR_LSB +: $bits(addr_t)];
  assign need_words    = aux_word[AUX_BURST_LSB +: BURST_W];
  assign brake_timeout = (brake_cnt == BRAKE_W'(BUS_TIMEOUT));
  assign wr_done       = ddr_write && !ddr_waitrequest;

  // combinational so the ring has moved on by the time we are back in idle
  assign advance = (state == ST_AUX_CHECK && !aux_owner) ||
                   (state == ST_WR_AUX && (wr_done || brake_timeout));

  always_ff @(posedge ethSw) begin
    if (rst || !work_ena) begin
      state              <= ST_IDLE;
      ddr_read           <= 1'b0;
      ddr_write          <= 1'b0;
      tx_valid           <= 1'b0;
      tx_sop             <= 1'b0;
      tx_eop             <= 1'b0;
      tx_err             <= 1'b0;
      tx_irq             <= 1'b0;
      brake_cnt          <= '0;
      first_word         <= 1'b0;
      ev_rd_aux_timeout  <= 1'b0;
      ev_owner_err       <= 1'b0;
      ev_size_err        <= 1'b0;
      ev_rd_data_timeout <= 1'b0;
      ev_wr_aux_timeout  <= 1'b0;
      ev_postponed       <= 1'b0;
      ev_sent            <= 1'b0;
    end
    else begin
      // stream flags and event lines are single-cycle unless a state holds them
      tx_valid           <= 1'b0;
      tx_sop             <= 1'b0;
      tx_eop             <= 1'b0;
      tx_err             <= 1'b0;
      ev_rd_aux_timeout  <= 1'b0;
      ev_owner_err       <= 1'b0;
      ev_size_err        <= 1'b0;
      ev_rd_data_timeout <= 1'b0;
      ev_wr_aux_timeout  <= 1'b0;
      ev_postponed       <= 1'b0;
      ev_sent            <= 1'b0;

      case (state)
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // descriptor fetch and check
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        ST_IDLE: begin
          if (pending) begin
            ddr_address    <= cur_addr;
            ddr_burstcount <= burst_t'(1); // the aux word alone
            ddr_read       <= 1'b1;
            brake_cnt      <= '0;
            state          <= ST_RD_AUX;
          end
        end
        ST_RD_AUX: begin
          if (ddr_read && !ddr_waitrequest)
            ddr_read <= 1'b0;
          if (ddr_readdatavalid) begin
            aux_word <= ddr_readdata;
            state    <= ST_AUX_CHECK;
          end
          else if (brake_timeout) begin
            ddr_read          <= 1'b0;
            ev_rd_aux_timeout <= 1'b1;
            state             <= ST_IDLE;
          end
          else
            brake_cnt <= brake_cnt + 1'b1;
        end
        ST_AUX_CHECK: begin
          if (!aux_owner) begin
            ev_owner_err <= 1'b1; // host still owns it, skip without write-back
            state        <= ST_IDLE;
          end
          else if (aux_len < pack_len_t'(MIN_FRAME_B) || aux_len > pack_len_t'(MAX_FRAME_B)) begin
            ev_size_err                <= 1'b1;
            aux_word[AUX_OWNER_BIT]    <= 1'b0;
            aux_word[AUX_ERR_LSB +: 4] <= TX_SIZE_ERR;
            state                      <= ST_END;
          end
          else begin
            aux_word[AUX_OWNER_BIT]    <= 1'b0;
            aux_word[AUX_ERR_LSB +: 4] <= TX_OK;
            state                      <= ST_CREDIT_CHECK;
          end
        end
        ST_CREDIT_CHECK: begin
          if (has_room) begin
            ddr_address    <= aux_buf_addr;
            ddr_burstcount <= need_words;
            ddr_read       <= 1'b1;
            beats_left     <= need_words - 1'b1;
            first_word     <= 1'b1;
            brake_cnt      <= '0;
            state          <= ST_PACK_RD;
          end
          else begin
            // queue too full, the descriptor stays put and is fetched again
            ev_postponed <= 1'b1;
            state        <= ST_IDLE;
          end
        end
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // packet burst into the queue
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        ST_PACK_RD: begin
          if (ddr_read && !ddr_waitrequest)
            ddr_read <= 1'b0;
          tx_data <= ddr_readdata;
          if (ddr_readdatavalid) begin
            tx_valid   <= 1'b1;
            tx_sop     <= first_word;
            first_word <= 1'b0;
            brake_cnt  <= '0; // each word restarts the timer
            beats_left <= beats_left - 1'b1;
            if (beats_left == '0) begin
              tx_eop  <= 1'b1;
              ev_sent <= 1'b1;
              state   <= ST_END;
            end
          end
          else if (brake_timeout) begin
            // cut the frame short so the queue can drop it
            ddr_read                   <= 1'b0;
            tx_eop                     <= 1'b1;
            tx_err                     <= 1'b1;
            ev_rd_data_timeout         <= 1'b1;
            aux_word[AUX_ERR_LSB +: 4] <= TX_RD_TIMEOUT;
            state                      <= ST_END;
          end
          else
            brake_cnt <= brake_cnt + 1'b1;
        end
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // aux write-back
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        ST_END: begin
          ddr_address    <= cur_addr;
          ddr_burstcount <= burst_t'(1);
          ddr_writedata  <= aux_word;
          ddr_write      <= 1'b1;
          brake_cnt      <= '0;
          state          <= ST_WR_AUX;
        end
        ST_WR_AUX: begin
          if (wr_done || brake_timeout) begin
            ddr_write <= 1'b0;
            tx_irq    <= ~tx_irq; // descriptor finished, host may reclaim it
            if (!wr_done)
              ev_wr_aux_timeout <= 1'b1;
            state <= ST_IDLE;
          end
          else
            brake_cnt <= brake_cnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  a_rd_wr_excl : assert property (
    @(posedge ethSw) disable iff (rst)
    !(ddr_read && ddr_write)
  ) else $error("ddr read and write issued together");

  // an aborted frame closes without a data word
  a_eop_framing : assert property (
    @(posedge ethSw) disable iff (rst)
    tx_eop |-> (tx_valid || tx_err)
  ) else $error("end of packet without data or error");

endmodule

// File: rtl/tx_credit_tracker.sv
`timescale 1ns/1ps

module tx_credit_tracker import dma_pkg::*; #(
  parameter int TXQ_CREDITS = 64
) (
  input  logic   ethSw,
  input  logic   rst,
  input  logic   work_ena,
  input  logic   tx_valid,
  input  logic   tx_credit_return,
  input  burst_t need_words,
  output logic   has_room
);

  credit_t credits; // free words in the transmit queue

  // a burst may start only when every word of it already has a slot
  assign has_room = (credits >= credit_t'(need_words));

  always_ff @(posedge ethSw) begin
    if (rst || !work_ena)
      credits <= credit_t'(TXQ_CREDITS);
    else begin
      case ({tx_valid, tx_credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // spent and returned in the same cycle
      endcase
    end
  end

  // the queue must never hand back more than it was given
  a_credit_bounds : assert property (
    @(posedge ethSw) disable iff (rst || !work_ena)
    ((tx_valid && !tx_credit_return) |-> credits != '0) and
    ((tx_credit_return && !tx_valid) |-> credits != credit_t'(TXQ_CREDITS))
  ) else $error("credit count out of range");

endmodule

// File: rtl/dma_event_counters.sv
`timescale 1ns/1ps

module dma_event_counters import dma_pkg::*; (
  input  logic     ethSw,
  input  logic     rst,
  input  logic     work_ena,
  input  logic     ev_rd_aux_timeout,
  input  logic     ev_owner_err,
  input  logic     ev_size_err,
  input  logic     ev_rd_data_timeout,
  input  logic     ev_wr_aux_timeout,
  input  logic     ev_postponed,
  input  logic     ev_sent,
  input  cnt_sel_t cnt_sel,
  output err_cnt_t cnt_readout,
  output logic     tx_err_irq
);

  localparam int N_EV = 7;

  logic [N_EV-1:0] ev;
  err_cnt_t        cnt [N_EV];

  // the five error events sit in the low bits
  assign ev = {ev_sent, ev_postponed, ev_wr_aux_timeout, ev_rd_data_timeout,
               ev_size_err, ev_owner_err, ev_rd_aux_timeout};

  for (genvar i = 0; i < N_EV; i++) begin : g_cnt
    always_ff @(posedge ethSw) begin
      if (rst || !work_ena)
        cnt[i] <= '0;
      else if (ev[i])
        cnt[i] <= cnt[i] + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // indirect readout and error interrupt
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge ethSw) begin
    if (rst || !work_ena) begin
      cnt_readout <= '0;
      tx_err_irq  <= 1'b0;
    end
    else begin
      tx_err_irq <= tx_err_irq ^ (^ev[4:0]); // postponed and sent are not errors
      case (cnt_sel)
        SEL_RD_AUX_TIMEOUT:  cnt_readout <= cnt[0];
        SEL_OWNER_ERR:       cnt_readout <= cnt[1];
        SEL_SIZE_ERR:        cnt_readout <= cnt[2];
        SEL_RD_DATA_TIMEOUT: cnt_readout <= cnt[3];
        SEL_WR_AUX_TIMEOUT:  cnt_readout <= cnt[4];
        SEL_POSTPONED:       cnt_readout <= cnt[5];
        SEL_SENT:            cnt_readout <= cnt[6];
        default:             cnt_readout <= '0;
      endcase
    end
  end

endmodule

// File: rtl/arm_tx_dma.sv
`timescale 1ns/1ps

module arm_tx_dma import dma_pkg::*; #(
  parameter int BUS_TIMEOUT = 1023,
  parameter int DESC_STRIDE = 4,
  parameter int TXQ_CREDITS = 64
) (
  input  logic      ethSw,
  input  logic      rst,
  input  logic      work_ena,
  // host side
  input  addr_t     ring_base,
  input  ring_idx_t host_prod_idx,
  input  cnt_sel_t  cnt_sel,
  // ddr master bus
  output addr_t     ddr_address,
  output logic      ddr_read,
  output logic      ddr_write,
  output bus_word_t ddr_writedata,
  output burst_t    ddr_burstcount,
  input  bus_word_t ddr_readdata,
  input  logic      ddr_waitrequest,
  input  logic      ddr_readdatavalid,
  // transmit queue stream
  output bus_word_t tx_data,
  output logic      tx_valid,
  output logic      tx_sop,
  output logic      tx_eop,
  output logic      tx_err,
  input  logic      tx_credit_return,
  // status
  output ring_idx_t cons_idx,
  output err_cnt_t  cnt_readout,
  output logic      tx_irq,
  output logic      tx_err_irq
);

  addr_t  cur_addr;
  logic   pending;
  logic   advance;
  logic   has_room;
  burst_t need_words;

  logic ev_rd_aux_timeout;
  logic ev_owner_err;
  logic ev_size_err;
  logic ev_rd_data_timeout;
  logic ev_wr_aux_timeout;
  logic ev_postponed;
  logic ev_sent;

  tx_desc_ring #(
    .DESC_STRIDE (DESC_STRIDE)
  ) u_ring (
    .ethSw         (ethSw),
    .rst           (rst),
    .work_ena      (work_ena),
    .ring_base     (ring_base),
    .host_prod_idx (host_prod_idx),
    .advance       (advance),
    .cur_addr      (cur_addr),
    .cons_idx      (cons_idx),
    .pending       (pending)
  );

  tx_dma_ctrl #(
    .BUS_TIMEOUT (BUS_TIMEOUT)
  ) u_ctrl (
    .ethSw              (ethSw),
    .rst                (rst),
    .work_ena           (work_ena),
    .pending            (pending),
    .cur_addr           (cur_addr),
    .has_room           (has_room),
    .ddr_address        (ddr_address),
    .ddr_read           (ddr_read),
    .ddr_write          (ddr_write),
    .ddr_writedata      (ddr_writedata),
    .ddr_burstcount     (ddr_burstcount),
    .ddr_readdata       (ddr_readdata),
    .ddr_waitrequest    (ddr_waitrequest),
    .ddr_readdatavalid  (ddr_readdatavalid),
    .tx_data            (tx_data),
    .tx_valid           (tx_valid),
    .tx_sop             (tx_sop),
    .tx_eop             (tx_eop),
    .tx_err             (tx_err),
    .advance            (advance),
    .need_words         (need_words),
    .ev_rd_aux_timeout  (ev_rd_aux_timeout),
    .ev_owner_err       (ev_owner_err),
    .ev_size_err        (ev_size_err),
    .ev_rd_data_timeout (ev_rd_data_timeout),
    .ev_wr_aux_timeout  (ev_wr_aux_timeout),
    .ev_postponed       (ev_postponed),
    .ev_sent            (ev_sent),
    .tx_irq             (tx_irq)
  );

  tx_credit_tracker #(
    .TXQ_CREDITS (TXQ_CREDITS)
  ) u_credit (
    .ethSw            (ethSw),
    .rst              (rst),
    .work_ena         (work_ena),
    .tx_valid         (tx_valid),
    .tx_credit_return (tx_credit_return),
    .need_words       (need_words),
    .has_room         (has_room)
  );

  dma_event_counters u_cnt (
    .ethSw              (ethSw),
    .rst                (rst),
    .work_ena           (work_ena),
    .ev_rd_aux_timeout  (ev_rd_aux_timeout),
    .ev_owner_err       (ev_owner_err),
    .ev_size_err        (ev_size_err),
    .ev_rd_data_timeout (ev_rd_data_timeout),
    .ev_wr_aux_timeout  (ev_wr_aux_timeout),
    .ev_postponed       (ev_postponed),
    .ev_sent            (ev_sent),
    .cnt_sel            (cnt_sel),
    .cnt_readout        (cnt_readout),
    .tx_err_irq         (tx_err_irq)
  );

endmodule

// File: test/tb_clk.sv
`timescale 1ns/1ps

module tb_clk #(
  parameter int RST_CYCLES = 16
) (
  output logic ethSw,
  output logic rst
);

  initial begin
    ethSw = 1'b0;
    forever #5 ethSw = ~ethSw; // 10 ns period
  end

  // reset is released on a rising edge so it behaves like a synchronous input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge ethSw);
    rst <= 1'b0;
  end

endmodule

// File: test/ddr_model.sv
`timescale 1ns/1ps

module ddr_model import dma_pkg::*; (
  input  logic      ethSw,
  input  logic      rst,
  // ddr slave side
  input  addr_t     ddr_address,
  input  logic      ddr_read,
  input  logic      ddr_write,
  input  bus_word_t ddr_writedata,
  input  burst_t    ddr_burstcount,
  output bus_word_t ddr_readdata,
  output logic      ddr_waitrequest,
  output logic      ddr_readdatavalid,
  // test controls
  input  logic      stall,       // holds waitrequest high
  input  logic      mute_bursts, // multi-word reads are accepted but never answered
  input  logic      bd_we,
  input  addr_t     bd_addr,
  input  bus_word_t bd_data
);

  localparam int DEPTH = 1024;
  localparam int AW    = 10;

  bus_word_t mem [DEPTH]; // word addressed, upper address bits are ignored
  addr_t     rd_addr;
  burst_t    rd_left;

  assign ddr_waitrequest = stall;

  initial begin
    ddr_readdata      = '0;
    ddr_readdatavalid = 1'b0;
  end

  always @(posedge ethSw) begin
    if (rst) begin
      rd_left           <= '0;
      ddr_readdatavalid <= 1'b0;
    end
    else begin
      ddr_readdatavalid <= 1'b0;
      if (rd_left != '0) begin
        // one word per cycle, in address order
        ddr_readdata      <= mem[rd_addr[AW-1:0]];
        ddr_readdatavalid <= 1'b1;
        rd_addr           <= rd_addr + 1'b1;
        rd_left           <= rd_left - 1'b1;
      end
      else if (ddr_read && !stall && !(mute_bursts && ddr_burstcount > burst_t'(1))) begin
        rd_addr <= ddr_address;
        rd_left <= ddr_burstcount;
      end
      if (ddr_write && !stall)
        mem[ddr_address[AW-1:0]] <= ddr_writedata;
      if (bd_we)
        mem[bd_addr[AW-1:0]] <= bd_data; // preload port for descriptors and payload
    end
  end

endmodule

// File: test/tb_arm_tx_dma.sv
`timescale 1ns/1ps

module tb_arm_tx_dma import dma_pkg::*; ;

  localparam addr_t RING_BASE   = 32'h0000_0100;
  localparam addr_t BUF_BASE    = 32'h0000_0200;
  localparam addr_t BUF_STRIDE  = 32'd64;
  localparam addr_t DESC_STRIDE = 32'd4;
  localparam int    DONE_LIMIT  = 400;
  // about 3000 cycles of tests, so 20000 cycles leaves a wide margin
  localparam int    WATCHDOG_NS = 200_000;

  logic      ethSw;
  logic      rst;
  logic      work_ena;
  addr_t     ring_base;
  ring_idx_t host_prod_idx;
  cnt_sel_t  cnt_sel;
  addr_t     ddr_address;
  logic      ddr_read;
  logic      ddr_write;
  bus_word_t ddr_writedata;
  burst_t    ddr_burstcount;
  bus_word_t ddr_readdata;
  logic      ddr_waitrequest;
  logic      ddr_readdatavalid;
  bus_word_t tx_data;
  logic      tx_valid;
  logic      tx_sop;
  logic      tx_eop;
  logic      tx_err;
  logic      tx_credit_return = 1'b0;
  ring_idx_t cons_idx;
  err_cnt_t  cnt_readout;
  logic      tx_irq;
  logic      tx_err_irq;

  logic      stall;
  logic      mute_bursts;
  logic      bd_we;
  addr_t     bd_addr;
  bus_word_t bd_data;
  logic      hold_credits;

  // queue model state
  int        owed = 0;
  int        err_closes = 0;
  bus_word_t rx_words [$];
  logic      rx_sop [$];
  logic      rx_eop [$];
  logic      rx_err [$];

  // the descriptor currently under test
  bus_word_t exp_words [$];
  ring_idx_t desc_slot;
  addr_t     desc_addr;
  addr_t     desc_buf;
  pack_len_t desc_len;
  burst_t    desc_burst;
  int        rx_base;
  logic      irq_before;
  logic      err_irq_before;
  integer    seed;

  tb_clk clk0 (
    .ethSw (ethSw),
    .rst   (rst)
  );

  ddr_model ddr0 (
    .ethSw             (ethSw),
    .rst               (rst),
    .ddr_address       (ddr_address),
    .ddr_read          (ddr_read),
    .ddr_write         (ddr_write),
    .ddr_writedata     (ddr_writedata),
    .ddr_burstcount    (ddr_burstcount),
    .ddr_readdata      (ddr_readdata),
    .ddr_waitrequest   (ddr_waitrequest),
    .ddr_readdatavalid (ddr_readdatavalid),
    .stall             (stall),
    .mute_bursts       (mute_bursts),
    .bd_we             (bd_we),
    .bd_addr           (bd_addr),
    .bd_data           (bd_data)
  );

  arm_tx_dma #(
    .BUS_TIMEOUT (31),
    .DESC_STRIDE (4),
    .TXQ_CREDITS (64)
  ) dut0 (
    .ethSw             (ethSw),
    .rst               (rst),
    .work_ena          (work_ena),
    .ring_base         (ring_base),
    .host_prod_idx     (host_prod_idx),
    .cnt_sel           (cnt_sel),
    .ddr_address       (ddr_address),
    .ddr_read          (ddr_read),
    .ddr_write         (ddr_write),
    .ddr_writedata     (ddr_writedata),
    .ddr_burstcount    (ddr_burstcount),
    .ddr_readdata      (ddr_readdata),
    .ddr_waitrequest   (ddr_waitrequest),
    .ddr_readdatavalid (ddr_readdatavalid),
    .tx_data           (tx_data),
    .tx_valid          (tx_valid),
    .tx_sop            (tx_sop),
    .tx_eop            (tx_eop),
    .tx_err            (tx_err),
    .tx_credit_return  (tx_credit_return),
    .cons_idx          (cons_idx),
    .cnt_readout       (cnt_readout),
    .tx_irq            (tx_irq),
    .tx_err_irq        (tx_err_irq)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transmit queue model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge ethSw) begin
    if (rst) begin
      owed             <= 0;
      tx_credit_return <= 1'b0;
    end
    else begin
      if (tx_valid) begin
        rx_words.push_back(tx_data);
        rx_sop.push_back(tx_sop);
        rx_eop.push_back(tx_eop);
        rx_err.push_back(tx_err);
      end
      else if (tx_eop && tx_err)
        err_closes <= err_closes + 1; // aborted frame closed without data
      // one credit goes back per word the queue has taken in
      tx_credit_return <= (owed > 0) && !hold_credits;
      owed <= owed + int'(tx_valid) - int'((owed > 0) && !hold_credits);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare and helper tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_cnt(input err_cnt_t got, input err_cnt_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_idx(input ring_idx_t got, input ring_idx_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  function automatic bus_word_t make_aux(input addr_t buf_addr, input burst_t burst,
                                         input pack_len_t len, input logic owner,
                                         input err_code_t code);
    bus_word_t w;
    w = '0;
    w[AUX_ADDR_LSB +: 32]       = buf_addr;
    w[AUX_BURST_LSB +: BURST_W] = burst;
    w[AUX_ERR_LSB +: 4]         = code;
    w[AUX_OWNER_BIT]            = owner;
    w[AUX_LEN_LSB +: 11]        = len;
    return w;
  endfunction

  // the host expects its descriptor back with ownership returned
  function automatic bus_word_t retired_aux(input err_code_t code);
    return make_aux(desc_buf, desc_burst, desc_len, 1'b0, code);
  endfunction

  function automatic bus_word_t peek(input addr_t a);
    return ddr0.mem[a[9:0]];
  endfunction

  task automatic poke(input addr_t a, input bus_word_t d);
    @(posedge ethSw);
    bd_we   <= 1'b1;
    bd_addr <= a;
    bd_data <= d;
    @(posedge ethSw);
    bd_we   <= 1'b0;
  endtask

  task automatic post_desc(input logic owner, input pack_len_t len, input burst_t burst);
    bus_word_t w;
    desc_slot  = host_prod_idx;
    desc_addr  = RING_BASE + addr_t'(desc_slot) * DESC_STRIDE;
    desc_buf   = BUF_BASE + addr_t'(desc_slot) * BUF_STRIDE;
    desc_len   = len;
    desc_burst = burst;
    exp_words.delete();
    for (int i = 0; i < int'(burst); i++) begin
      w = {$random(seed), $random(seed)};
      exp_words.push_back(w);
      poke(desc_buf + addr_t'(i), w);
    end
    poke(desc_addr, make_aux(desc_buf, burst, len, owner, TX_OK));
    rx_base        = rx_words.size();
    irq_before     = tx_irq;
    err_irq_before = tx_err_irq;
    @(posedge ethSw);
    host_prod_idx <= host_prod_idx + 1'b1;
  endtask

  task automatic wait_cons(input ring_idx_t idx);
    int n;
    n = 0;
    while (cons_idx !== idx) begin
      @(negedge ethSw);
      n++;
      if (n > DONE_LIMIT)
        abort_run($sformatf("descriptor in slot %0d was never completed", desc_slot));
    end
  endtask

  task automatic expect_cnt(input cnt_sel_t sel, input err_cnt_t exp, input string what);
    @(posedge ethSw);
    cnt_sel <= sel;
    repeat (3) @(posedge ethSw); // counter update plus the registered readout
    @(negedge ethSw);
    check_cnt(cnt_readout, exp, what);
  endtask

  task automatic check_stream();
    int n;
    n = exp_words.size();
    check_cnt(err_cnt_t'(rx_words.size() - rx_base), err_cnt_t'(n), "stream word count");
    for (int i = 0; i < n; i++) begin
      check_word(rx_words[rx_base + i], exp_words[i], "stream data");
      check_bit(rx_sop[rx_base + i], i == 0, "tx_sop");
      check_bit(rx_eop[rx_base + i], i == n - 1, "tx_eop");
      check_bit(rx_err[rx_base + i], 1'b0, "tx_err");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_good_packet();
    stall <= 1'b1; // the aux read waits a few cycles on the bus
    post_desc(1'b1, 11'd100, 8'd13);
    repeat (6) @(posedge ethSw);
    stall <= 1'b0;
    wait_cons(desc_slot + 1'b1);
    check_stream();
    check_word(peek(desc_addr), retired_aux(TX_OK), "aux write-back");
    check_bit(tx_irq, ~irq_before, "tx_irq");
    expect_cnt(SEL_SENT, 16'd1, "sent counter");
    check_idx(cons_idx, 3'd1, "cons_idx");
  endtask

  task automatic test_owner_error();
    bus_word_t posted;
    post_desc(1'b0, 11'd100, 8'd13);
    posted = peek(desc_addr);
    wait_cons(desc_slot + 1'b1);
    expect_cnt(SEL_OWNER_ERR, 16'd1, "owner error counter");
    check_cnt(err_cnt_t'(rx_words.size() - rx_base), '0, "stream word count");
    check_word(peek(desc_addr), posted, "untouched aux word");
    check_bit(tx_irq, irq_before, "tx_irq");
    check_bit(tx_err_irq, ~err_irq_before, "tx_err_irq");
  endtask

  task automatic test_size_error();
    post_desc(1'b1, 11'd20, 8'd13); // shorter than a minimum frame
    wait_cons(desc_slot + 1'b1);
    expect_cnt(SEL_SIZE_ERR, 16'd1, "size error counter");
    check_cnt(err_cnt_t'(rx_words.size() - rx_base), '0, "stream word count");
    check_word(peek(desc_addr), retired_aux(TX_SIZE_ERR), "aux write-back");
    check_bit(tx_irq, ~irq_before, "tx_irq");
    check_bit(tx_err_irq, ~err_irq_before, "tx_err_irq");
  endtask

  task automatic test_credit_backpressure();
    int n;
    hold_credits <= 1'b1;
    post_desc(1'b1, 11'd480, 8'd60); // leaves four credits in the engine
    wait_cons(desc_slot + 1'b1);
    check_stream();
    post_desc(1'b1, 11'd100, 8'd13);
    @(posedge ethSw);
    cnt_sel <= SEL_POSTPONED;
    n = 0;
    do begin
      @(negedge ethSw);
      n++;
      if (n > DONE_LIMIT)
        abort_run("postponed counter never rose while credits were held");
    end while (cnt_readout < 16'd2);
    check_cnt(err_cnt_t'(rx_words.size() - rx_base), '0, "words sent without credit");
    check_idx(cons_idx, desc_slot, "cons_idx while held");
    hold_credits <= 1'b0;
    wait_cons(desc_slot + 1'b1);
    check_stream();
    check_word(peek(desc_addr), retired_aux(TX_OK), "aux write-back");
  endtask

  task automatic test_read_timeout();
    int closes_before;
    closes_before = err_closes;
    mute_bursts <= 1'b1;
    post_desc(1'b1, 11'd100, 8'd13);
    wait_cons(desc_slot + 1'b1);
    mute_bursts <= 1'b0;
    expect_cnt(SEL_RD_DATA_TIMEOUT, 16'd1, "read data timeout counter");
    check_cnt(err_cnt_t'(rx_words.size() - rx_base), '0, "stream word count");
    check_cnt(err_cnt_t'(err_closes - closes_before), 16'd1, "error closes");
    check_word(peek(desc_addr), retired_aux(TX_RD_TIMEOUT), "aux write-back");
    check_bit(tx_irq, ~irq_before, "tx_irq");
  endtask

  task automatic test_ring_wrap();
    // the last pass posts the ninth descriptor into slot zero at the ring base
    for (int k = 0; k < 3; k++) begin
      post_desc(1'b1, 11'd100, 8'd13);
      wait_cons(desc_slot + 1'b1);
      check_stream();
      check_word(peek(desc_addr), retired_aux(TX_OK), "aux write-back");
    end
    expect_cnt(SEL_SENT, 16'd6, "sent counter");
    check_idx(cons_idx, 3'd1, "cons_idx after the wrap");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    seed          = 6;
    work_ena      = 1'b0;
    ring_base     = RING_BASE;
    host_prod_idx = '0;
    cnt_sel       = SEL_SENT;
    stall         = 1'b0;
    mute_bursts   = 1'b0;
    bd_we         = 1'b0;
    bd_addr       = '0;
    bd_data       = '0;
    hold_credits  = 1'b0;
    @(negedge rst);
    @(posedge ethSw);
    work_ena <= 1'b1;
    test_good_packet();
    test_owner_error();
    test_size_error();
    test_credit_backpressure();
    test_read_timeout();
    test_ring_wrap();
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

// File: tb.f
rtl/dma_pkg.sv
rtl/tx_desc_ring.sv
rtl/tx_dma_ctrl.sv
rtl/tx_credit_tracker.sv
rtl/dma_event_counters.sv
rtl/arm_tx_dma.sv
test/tb_clk.sv
test/ddr_model.sv
test/tb_arm_tx_dma.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_arm_tx_dma \
  -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
